/* include/pic_defines.svh */
// Sizing macros for the interrupt controller, included by the package and the RTL modules
`ifndef PIC_DEFINES_SVH
`define PIC_DEFINES_SVH

// Number of interrupt request lines handled by the controller
`define PIC_NUM_LINES 8

// Width of the CPU bus data path
// Lane 0 is the command port and lane 1 is the data port
`define PIC_DATA_W 16

// Width of the vector base taken from ICW2
// It forms the upper bits of the vector, above the line number
`define PIC_VBASE_W 5

`endif

/* source/pic_pkg.sv */
// Shared enums and bus structs for the interrupt controller, imported by every RTL module
`include "pic_defines.svh"

package pic_pkg;

    // Initialization sequencer, IDLE once all four ICWs are written
    typedef enum logic [2:0] {
        INIT_ICW1,
        INIT_ICW2,
        INIT_ICW3,
        INIT_ICW4,
        INIT_IDLE
    } init_state_t;

    // What a command-port read returns in the low byte
    typedef enum logic [1:0] {
        LATCH_NONE,
        LATCH_IRR,
        LATCH_ISR
    } reg_latch_t;

    typedef enum logic [1:0] {
        EOI_NONE,
        EOI_NONSPECIFIC,
        EOI_SPECIFIC
    } eoi_kind_t;

    // CPU side request, held until ack is seen
    typedef struct packed {
        logic                   cs;
        logic                   access;
        logic                   wr_en;
        logic [1:0]             bytesel;
        logic [`PIC_DATA_W-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic [`PIC_DATA_W-1:0] rdata;
        logic                   ack;
    } bus_rsp_t;

    // Single-cycle end-of-interrupt command towards the core
    typedef struct packed {
        eoi_kind_t  kind;
        logic [2:0] level;
    } eoi_cmd_t;

endpackage

/* source/pic_config_regs.sv */
// CPU register port of the interrupt controller: init sequence, mask, EOI decode and reads
`timescale 1ns/10ps
`include "pic_defines.svh"

module pic_config_regs (
    input  logic                          clk,
    input  logic                          reset,
    input  pic_pkg::bus_req_t             bus_req,
    output pic_pkg::bus_rsp_t             bus_rsp,
    input  logic [`PIC_NUM_LINES-1:0]     irr,
    input  logic [`PIC_NUM_LINES-1:0]     isr,
    output logic [`PIC_NUM_LINES-1:0]     mask,
    output logic [`PIC_VBASE_W-1:0]       vector_base,
    output pic_pkg::eoi_cmd_t             eoi,
    output pic_pkg::init_state_t          init_state
);
    import pic_pkg::*;

    reg_latch_t               read_sel;
    logic                     ack;
    logic [`PIC_DATA_W-1:0]   rdata;
    logic                     accept;
    logic                     cmd_wr;
    logic                     data_wr;
    logic                     is_idle;
    logic [7:0]               cmd_byte;
    logic [`PIC_NUM_LINES-1:0] sel_data;

    // A transfer is taken once, the cycle before ack
    assign accept  = bus_req.cs & bus_req.access & ~ack;
    assign cmd_wr  = accept & bus_req.wr_en & bus_req.bytesel[0];
    assign data_wr = accept & bus_req.wr_en & bus_req.bytesel[1];
    assign is_idle = (init_state == INIT_IDLE);
    assign cmd_byte = bus_req.wdata[7:0];

    // ICW1 needs bit 4 on the command port, ICW2 to ICW4 are data writes
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            init_state <= INIT_ICW1;
        end else begin
            case (init_state)
                INIT_ICW1: if (cmd_wr && cmd_byte[4]) init_state <= INIT_ICW2;
                INIT_ICW2: if (data_wr) init_state <= INIT_ICW3;
                INIT_ICW3: if (data_wr) init_state <= INIT_ICW4;
                INIT_ICW4: if (data_wr) init_state <= INIT_IDLE;
                INIT_IDLE: init_state <= INIT_IDLE;
                default:   init_state <= INIT_ICW1;
            endcase
        end
    end

    // Vector base sits in the top bits of the ICW2 word
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vector_base <= '0;
        end else if (data_wr && init_state == INIT_ICW2) begin
            vector_base <= bus_req.wdata[`PIC_DATA_W-1 -: `PIC_VBASE_W];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mask <= '0;
        end else if (data_wr && is_idle) begin
            mask <= bus_req.wdata[`PIC_DATA_W-1 -: `PIC_NUM_LINES];
        end
    end

    // Read select command, 10 for IRR and 11 for ISR
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            read_sel <= LATCH_NONE;
        end else if (cmd_wr && is_idle && cmd_byte[3]) begin
            case (cmd_byte[1:0])
                2'b10:   read_sel <= LATCH_IRR;
                2'b11:   read_sel <= LATCH_ISR;
                default: read_sel <= LATCH_NONE;
            endcase
        end
    end

    // EOI is combinational so that the core clears ISR on the accept edge
    always_comb begin
        eoi.kind  = EOI_NONE;
        eoi.level = cmd_byte[2:0];
        if (cmd_wr && is_idle && cmd_byte[4:3] == 2'b00) begin
            case (cmd_byte[7:5])
                3'b001:  eoi.kind = EOI_NONSPECIFIC;
                3'b011:  eoi.kind = EOI_SPECIFIC;
                default: eoi.kind = EOI_NONE;
            endcase
        end
    end

    always_comb begin
        case (read_sel)
            LATCH_IRR: sel_data = irr;
            LATCH_ISR: sel_data = isr;
            default:   sel_data = '0;
        endcase
    end

    // Read data is only non-zero in the ack cycle of a read
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack   <= 1'b0;
            rdata <= '0;
        end else begin
            ack   <= accept;
            rdata <= (accept && !bus_req.wr_en) ? {mask, sel_data} : '0;
        end
    end

    assign bus_rsp.ack   = ack;
    assign bus_rsp.rdata = rdata;

endmodule

/* source/pic_irq_core.sv */
// Interrupt core: edge capture, IRR and ISR registers, fixed priority and acknowledge
`timescale 1ns/10ps
`include "pic_defines.svh"

module pic_irq_core (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [`PIC_NUM_LINES-1:0]     intr_in,
    input  logic [`PIC_NUM_LINES-1:0]     mask,
    input  logic [`PIC_VBASE_W-1:0]       vector_base,
    input  pic_pkg::eoi_cmd_t             eoi,
    input  logic                          inta,
    output logic [`PIC_NUM_LINES-1:0]     irr,
    output logic [`PIC_NUM_LINES-1:0]     isr,
    output logic                          intr,
    output logic [7:0]                    vector
);
    import pic_pkg::*;

    localparam int N = `PIC_NUM_LINES;
    localparam logic [N-1:0] ONE = 1;

    logic [N-1:0] intr_last;
    logic [N-1:0] edges;
    logic [N-1:0] ack_bit;
    logic [N-1:0] eoi_clr;
    logic [2:0]   pick;
    logic [2:0]   lowest_isr;
    logic [2:0]   delivered;
    logic         delivered_vld;
    logic         found;
    logic         blocked;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            intr_last <= '0;
        end else begin
            intr_last <= intr_in;
        end
    end

    assign edges = intr_in & ~intr_last;

    // Walk from line 0 upwards, an in-service line stops the search
    always_comb begin
        found   = 1'b0;
        blocked = 1'b0;
        pick    = '0;
        for (int i = 0; i < N; i++) begin
            if (!found && !blocked) begin
                if (isr[i]) begin
                    blocked = 1'b1;
                end else if (irr[i]) begin
                    found = 1'b1;
                    pick  = i[2:0];
                end
            end
        end
    end

    assign intr   = found & ~inta;
    assign vector = intr ? {vector_base, pick} : '0;

    // Downward scan leaves the lowest set ISR bit
    always_comb begin
        lowest_isr = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (isr[i]) lowest_isr = i[2:0];
        end
    end

    always_comb begin
        case (eoi.kind)
            EOI_NONSPECIFIC: eoi_clr = isr & (ONE << lowest_isr);
            EOI_SPECIFIC:    eoi_clr = ONE << eoi.level;
            default:         eoi_clr = '0;
        endcase
    end

    // Line that was on offer in the cycle before inta
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            delivered     <= '0;
            delivered_vld <= 1'b0;
        end else begin
            delivered_vld <= intr;
            if (intr) delivered <= pick;
        end
    end

    assign ack_bit = (inta && delivered_vld) ? (ONE << delivered) : '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            irr <= '0;
            isr <= '0;
        end else begin
            irr <= (irr & ~ack_bit) | (edges & ~mask);
            isr <= (isr & ~eoi_clr) | ack_bit;
        end
    end

endmodule

/* source/pic_top.sv */
// Top level of the interrupt controller, joins the register port and the interrupt core
`timescale 1ns/10ps
`include "pic_defines.svh"

module pic_top (
    input  logic                          clk,
    input  logic                          reset,
    input  pic_pkg::bus_req_t             bus_req,
    output pic_pkg::bus_rsp_t             bus_rsp,
    input  logic [`PIC_NUM_LINES-1:0]     intr_in,
    input  logic                          inta,
    output logic                          intr,
    output logic [7:0]                    vector
);
    import pic_pkg::*;

    logic [`PIC_NUM_LINES-1:0] mask;
    logic [`PIC_NUM_LINES-1:0] irr;
    logic [`PIC_NUM_LINES-1:0] isr;
    logic [`PIC_VBASE_W-1:0]   vector_base;
    eoi_cmd_t                  eoi;
    init_state_t               init_state;

    pic_config_regs u_regs (
        .clk         (clk),
        .reset       (reset),
        .bus_req     (bus_req),
        .bus_rsp     (bus_rsp),
        .irr         (irr),
        .isr         (isr),
        .mask        (mask),
        .vector_base (vector_base),
        .eoi         (eoi),
        .init_state  (init_state)
    );

    pic_irq_core u_core (
        .clk         (clk),
        .reset       (reset),
        .intr_in     (intr_in),
        .mask        (mask),
        .vector_base (vector_base),
        .eoi         (eoi),
        .inta        (inta),
        .irr         (irr),
        .isr         (isr),
        .intr        (intr),
        .vector      (vector)
    );

endmodule

/* tests/pic_assertions.sv */
// Protocol and init state assertions for the interrupt controller, bound into pic_top
`timescale 1ns/10ps

module pic_assertions (
    input logic                 clk,
    input logic                 reset,
    input pic_pkg::bus_rsp_t    bus_rsp,
    input logic                 inta,
    input logic                 intr,
    input pic_pkg::eoi_cmd_t    eoi,
    input pic_pkg::init_state_t init_state
);
    import pic_pkg::*;

    // Ack is a one-cycle pulse per transfer
    ack_single_cycle: assert property (@(posedge clk) disable iff (reset)
        bus_rsp.ack |=> !bus_rsp.ack)
        else $error("ack stayed high for two cycles");

    intr_low_in_inta: assert property (@(posedge clk) disable iff (reset)
        inta |-> !intr)
        else $error("intr high while inta is asserted");

    // Nothing is decoded or offered before the ICW sequence is done
    no_eoi_before_idle: assert property (@(posedge clk) disable iff (reset)
        (init_state != INIT_IDLE) |-> (eoi.kind == EOI_NONE))
        else $error("EOI decoded before init finished");

    no_intr_before_idle: assert property (@(posedge clk) disable iff (reset)
        (init_state != INIT_IDLE) |-> !intr)
        else $error("intr raised before init finished");

endmodule

bind pic_top pic_assertions u_assertions (
    .clk        (clk),
    .reset      (reset),
    .bus_rsp    (bus_rsp),
    .inta       (inta),
    .intr       (intr),
    .eoi        (eoi),
    .init_state (init_state)
);

/* tests/pic_tb.sv */
// Self-checking testbench for the interrupt controller and top module of the simulation run
`timescale 1ns/10ps
`include "pic_defines.svh"

module pic_tb;
    import pic_pkg::*;

    localparam logic [4:0] VBASE     = 5'b01000;
    localparam int         TIMEOUT   = 50;
    localparam int         NUM_CASES = 8;

    // Style 0 is non-specific EOI, 1 is specific EOI and 2 holds the first EOI back
    typedef struct packed {
        logic [7:0]  mask;
        logic [7:0]  lines;
        logic [63:0] vecs;
        logic [1:0]  style;
    } test_case_t;

    logic                      clk;
    logic                      reset;
    bus_req_t                  bus_req;
    bus_rsp_t                  bus_rsp;
    logic [`PIC_NUM_LINES-1:0] intr_in;
    logic                      inta;
    logic                      intr;
    logic [7:0]                vector;

    test_case_t                cases [NUM_CASES];
    test_case_t                tc;
    logic [15:0]               rd_word;
    logic [7:0]                cur_mask;
    logic [7:0]                pending;
    logic [2:0]                line;
    logic [31:0]               rnd;
    logic                      timed_out;
    integer                    seed;
    int                        cnt;
    int                        errors;
    int                        case_errors;
    int                        failed_tests;
    int                        tests_run;

    pic_top UUT (
        .clk     (clk),
        .reset   (reset),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .intr_in (intr_in),
        .inta    (inta),
        .intr    (intr),
        .vector  (vector)
    );

    always #10 clk = ~clk;

    // Parks the calling process while the watcher block ends the run
    task automatic report_timeout(input string what);
        $display("ERROR timeout while waiting for %s", what);
        timed_out = 1'b1;
        forever @(posedge clk);
    endtask

    task automatic check_hex(input string name, input logic [15:0] got, input logic [15:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
            case_errors++;
        end
    endtask

    // Holds access until the one-cycle ack, then drops the request
    task automatic bus_xfer(input logic wr, input logic [1:0] lane, input logic [15:0] data);
        int n;
        n = 0;
        bus_req = '{cs: 1'b1, access: 1'b1, wr_en: wr, bytesel: lane, wdata: data};
        do begin
            @(posedge clk);
            #2;
            n = n + 1;
            if (n > TIMEOUT) report_timeout("bus ack");
        end while (!bus_rsp.ack);
        rd_word = bus_rsp.rdata;
        bus_req = '0;
    endtask

    task automatic write_cmd(input logic [7:0] cmd);
        bus_xfer(1'b1, 2'b01, {8'h00, cmd});
    endtask

    // Select IRR or ISR, then read mask and the selected register
    task automatic read_reg(input logic [7:0] sel, input logic [7:0] exp, input string name);
        write_cmd(sel);
        bus_xfer(1'b0, 2'b01, 16'h0000);
        check_hex(name, rd_word, {cur_mask, exp});
    endtask

    task automatic pulse(input logic [7:0] lines);
        intr_in = lines;
        @(posedge clk);
        #2;
        intr_in = '0;
    endtask

    // Intr must be on offer for a full cycle before inta
    task automatic serve_vector(input logic [7:0] exp);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #2;
            n = n + 1;
            if (n > TIMEOUT) report_timeout("intr");
        end while (!intr);
        @(posedge clk);
        #2;
        check_hex("intr", {15'h0, intr}, 16'h0001);
        check_hex("vector", {8'h00, vector}, {8'h00, exp});
        inta = 1'b1;
        @(posedge clk);
        #2;
        inta = 1'b0;
    endtask

    task automatic expect_no_intr();
        repeat (4) begin
            @(posedge clk);
            #2;
            check_hex("intr", {15'h0, intr}, 16'h0000);
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %-28s %s", name, (case_errors == 0) ? "ok" : "FAIL");
        tests_run++;
        errors += case_errors;
        if (case_errors != 0) failed_tests++;
        case_errors = 0;
    endtask

    // Packs the vectors lowest line first with one vector per byte
    function automatic logic [63:0] vectors_in_order(input logic [7:0] lines);
        logic [63:0] v;
        int k;
        v = '0;
        k = 0;
        for (int i = 0; i < 8; i++) begin
            if (lines[i]) begin
                v[8*k +: 8] = {VBASE, i[2:0]};
                k++;
            end
        end
        return v;
    endfunction

    initial begin
        wait (timed_out);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        bus_req = '0;
        intr_in = '0;
        inta = 1'b0;
        timed_out = 1'b0;
        cur_mask = 8'h00;
        seed = 32'h87a4_44be;
        errors = 0;
        case_errors = 0;
        failed_tests = 0;
        tests_run = 0;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;

        check_hex("intr", {15'h0, intr}, 16'h0000);
        check_hex("vector", {8'h00, vector}, 16'h0000);
        check_hex("ack", {15'h0, bus_rsp.ack}, 16'h0000);
        check_hex("rdata", bus_rsp.rdata, 16'h0000);
        // ICW1 goes to the command port and ICW2 to ICW4 to the data port
        bus_xfer(1'b1, 2'b01, 16'h0011);
        bus_xfer(1'b1, 2'b10, {VBASE, 11'h000});
        bus_xfer(1'b1, 2'b10, 16'h0000);
        bus_xfer(1'b1, 2'b10, 16'h0001);
        read_reg(8'h0A, 8'h00, "irr after init");
        read_reg(8'h0B, 8'h00, "isr after init");
        finish_test("reset and init");

        cases[0] = '{mask: 8'h00, lines: 8'h01, vecs: 64'h40, style: 2'd0};
        cases[1] = '{mask: 8'hF0, lines: 8'hF0, vecs: 64'h00, style: 2'd0};
        cases[2] = '{mask: 8'h00, lines: 8'h94, vecs: 64'h47_44_42, style: 2'd0};
        cases[3] = '{mask: 8'h10, lines: 8'h3A, vecs: 64'h45_43_41, style: 2'd1};
        cases[4] = '{mask: 8'h00, lines: 8'hC1, vecs: 64'h47_46_40, style: 2'd2};
        for (int i = 5; i < NUM_CASES; i++) begin
            rnd = $random(seed);
            cases[i].mask  = rnd[7:0];
            cases[i].lines = rnd[15:8];
            cases[i].vecs  = vectors_in_order(rnd[15:8] & ~rnd[7:0]);
            cases[i].style = 2'(i % 3);
        end

        foreach (cases[i]) begin
            tc = cases[i];
            cur_mask = tc.mask;
            bus_xfer(1'b1, 2'b10, {tc.mask, 8'h00});
            pending = tc.lines & ~tc.mask;
            cnt = $countones(pending);
            pulse(tc.lines);
            read_reg(8'h0A, pending, "irr after pulse");
            if (cnt == 0) expect_no_intr();
            for (int k = 0; k < cnt; k++) begin
                line = tc.vecs[8*k +: 3];
                serve_vector(tc.vecs[8*k +: 8]);
                pending[line] = 1'b0;
                read_reg(8'h0B, 8'h01 << line, "isr after inta");
                // Higher lines stay pending behind the one in service
                if (tc.style == 2'd2 && k == 0) begin
                    expect_no_intr();
                    read_reg(8'h0A, pending, "irr while in service");
                end
                write_cmd((tc.style == 2'd1) ? {5'b01100, line} : 8'h20);
            end
            read_reg(8'h0B, 8'h00, "isr after eoi");
            finish_test($sformatf("case %0d", i));
        end

        // Line 2 preempts line 5, then the EOIs unwind the nest
        cur_mask = 8'h00;
        bus_xfer(1'b1, 2'b10, 16'h0000);
        pulse(8'h20);
        serve_vector({VBASE, 3'd5});
        pulse(8'h80);
        expect_no_intr();
        read_reg(8'h0A, 8'h80, "irr behind line 5");
        pulse(8'h04);
        serve_vector({VBASE, 3'd2});
        read_reg(8'h0B, 8'h24, "isr nested");
        write_cmd(8'h20);
        read_reg(8'h0B, 8'h20, "isr after non-specific eoi");
        expect_no_intr();
        write_cmd(8'h65);
        serve_vector({VBASE, 3'd7});
        write_cmd(8'h67);
        read_reg(8'h0B, 8'h00, "isr after specific eoi");
        finish_test("nested service");

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, failed_tests, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* pic_lite.f */
+incdir+include
source/pic_pkg.sv
source/pic_config_regs.sv
source/pic_irq_core.sv
source/pic_top.sv
tests/pic_assertions.sv
tests/pic_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the interrupt controller testbench with Verilator, runs it and scans the log
set -u
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module pic_tb \
    -f pic_lite.f -o pic_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/pic_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$SIM_LOG"; then
    exit 1
fi
exit 0
